/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dbg_cnt
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "RESULT: FAIL" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/dbg_cnt_asserts.sv */
// ----------------------------
// bound checks on the debug counter
// read handshake, clear result and tick gating
// ----------------------------

`timescale 1ns/1ps

module dbg_cnt_asserts
  import dbg_cnt_pkg::*;
#(
  parameter int cnt_w = 16                           // counter width
) (
  input logic             clk_main_a0,
  input logic             rst_main_n,
  input logic             rd_en,
  input logic             rd_valid,
  input logic             cnt_enable,
  input logic             cnt_load,
  input logic             cnt_clear,
  input logic [cnt_w-1:0] count
);

  // a read is answered exactly one cycle later
  rd_answered: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    rd_en |=> rd_valid)
    else $error("rd_valid missing one cycle after rd_en");

  rd_no_extra: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    !rd_en |=> !rd_valid)
    else $error("rd_valid without a read one cycle before");

  clear_zeroes: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    cnt_clear |=> (count == '0))                    // clear wins over load and tick
    else $error("count not zero after cnt_clear");

  // no tick reaches the counter while disabled
  tick_gated: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    (!cnt_enable && !cnt_load && !cnt_clear) |=> $stable(count))
    else $error("count moved while cnt_enable is low");

endmodule

// both csr_block and event_counter signals meet at the top level
bind dbg_cnt_top dbg_cnt_asserts #(
  .cnt_w (cnt_w)
) u_asserts (
  .clk_main_a0 (clk_main_a0),
  .rst_main_n  (rst_main_n),
  .rd_en       (rd_en),
  .rd_valid    (rd_valid),
  .cnt_enable  (cnt_enable),
  .cnt_load    (cnt_load),
  .cnt_clear   (cnt_clear),
  .count       (count)
);

/* bench/tb_dbg_cnt.sv */
// ----------------------------
// testbench for the debug tick and event counter
// directed register tests with typed compares
// ----------------------------

`timescale 1ns/1ps

module tb_dbg_cnt
  import dbg_cnt_pkg::*;
();

  localparam int cnt_w  = 16;
  localparam int tick_w = 8;
  localparam logic [cnt_w-1:0] cnt_max = '1;
  // cycle budget: reset, identity, load/clear, tick rate, one-shot, wrap, watermark
  localparam int test_cycles = 4 + 8 + 14 + 55 + 26 + 26 + 28;

  logic              clk_main_a0;
  logic              rst_main_n;
  logic              wr_en;
  csr_addr_e         wr_addr;
  logic [data_w-1:0] wr_data;
  logic              rd_en;
  csr_addr_e         rd_addr;
  logic [data_w-1:0] rd_data;
  logic              rd_valid;
  logic              tick;
  logic              at_watermark;
  int                last_rd_lat;                    // cycles from capture to rd_valid

  dbg_cnt_top #(
    .cnt_w  (cnt_w),
    .tick_w (tick_w)
  ) UUT (
    .clk_main_a0  (clk_main_a0),
    .rst_main_n   (rst_main_n),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .tick         (tick),
    .at_watermark (at_watermark)
  );

  always #2 clk_main_a0 = ~clk_main_a0;              // 4 ns period

  // ----------------------------
  // failure and compare helpers
  // ----------------------------
  task automatic stop_on_error();
    $display("RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (act !== exp)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input logic [cnt_w-1:0] exp,
                             input logic [cnt_w-1:0] act);
    if (act !== exp)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  function automatic logic [data_w-1:0] ctrl_word(input logic en, input logic os,
                                                  input logic ld, input logic clr);
    logic [data_w-1:0] w;
    w               = '0;
    w[CTRL_ENABLE]  = en;
    w[CTRL_ONESHOT] = os;
    w[CTRL_LOAD]    = ld;                            // pulse bits
    w[CTRL_CLEAR]   = clr;
    return w;
  endfunction

  // ----------------------------
  // register port drivers
  // ----------------------------
  task automatic write_csr(input csr_addr_e addr, input logic [data_w-1:0] data);
    @(posedge clk_main_a0);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    @(posedge clk_main_a0);                          // DUT takes the write here
    wr_en   <= 1'b0;
  endtask

  task automatic read_csr(input csr_addr_e addr, output logic [data_w-1:0] data);
    @(posedge clk_main_a0);
    rd_en   <= 1'b1;
    rd_addr <= addr;
    @(posedge clk_main_a0);                          // DUT takes the read here
    rd_en   <= 1'b0;
    last_rd_lat = 1;
    @(negedge clk_main_a0);                          // sample mid cycle
    while (!rd_valid)
    begin
      if (last_rd_lat >= 4)
      begin
        $display("read of %s never returned rd_valid", addr.name());
        stop_on_error();
      end
      last_rd_lat++;
      @(negedge clk_main_a0);
    end
    data = rd_data;
  endtask

  // ----------------------------
  // directed tests
  // ----------------------------
  task automatic test_identity();
    logic [data_w-1:0] d;
    read_csr(CSR_ID, d);
    check_data("identity id", dbg_id_value, d);
    check_flag("identity id latency", 1'b1, last_rd_lat == 1);
    read_csr(CSR_VERSION, d);
    check_data("identity version", dbg_version_value, d);
    check_flag("identity version latency", 1'b1, last_rd_lat == 1);
  endtask

  task automatic test_load_clear();
    logic [data_w-1:0] d;
    logic [cnt_w-1:0]  val;
    val = cnt_w'($urandom);
    write_csr(CSR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0));
    write_csr(CSR_LOAD, data_w'(val));
    write_csr(CSR_CTRL, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0));
    read_csr(CSR_COUNT, d);
    check_count("load", val, d[cnt_w-1:0]);
    write_csr(CSR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
    read_csr(CSR_COUNT, d);
    check_count("clear", '0, d[cnt_w-1:0]);
  endtask

  task automatic test_tick_rate();
    logic [data_w-1:0] d;
    logic [cnt_w-1:0]  cnt;
    int                ticks;                        // pulses seen on the tick pin
    ticks = 0;
    write_csr(CSR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));   // zero count and divider
    write_csr(CSR_TICK, data_w'(3));
    write_csr(CSR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0));
    repeat (40)
    begin
      @(negedge clk_main_a0);                        // 40 enabled cycles, divider from 0
      if (tick)
        ticks++;
    end
    write_csr(CSR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0));
    read_csr(CSR_COUNT, d);
    cnt = d[cnt_w-1:0];
    check_flag($sformatf("tick rate count %0d in 9..11", cnt), 1'b1,
               (cnt >= cnt_w'(9)) && (cnt <= cnt_w'(11)));
    check_count("tick rate pin pulses", cnt_w'(40 / 4), cnt_w'(ticks));
    check_flag("tick rate pin while disabled", 1'b0, tick);
  endtask

  // load max-2, tick every cycle, run 10 cycles
  task automatic run_near_max(input logic oneshot, output logic [cnt_w-1:0] cnt);
    logic [data_w-1:0] d;
    write_csr(CSR_CTRL, ctrl_word(1'b0, oneshot, 1'b0, 1'b0));
    write_csr(CSR_LOAD, data_w'(cnt_max - cnt_w'(2)));
    write_csr(CSR_CTRL, ctrl_word(1'b0, oneshot, 1'b1, 1'b0));
    write_csr(CSR_TICK, '0);
    write_csr(CSR_CTRL, ctrl_word(1'b1, oneshot, 1'b0, 1'b0));
    repeat (10) @(posedge clk_main_a0);
    write_csr(CSR_CTRL, ctrl_word(1'b0, oneshot, 1'b0, 1'b0));
    read_csr(CSR_COUNT, d);
    cnt = d[cnt_w-1:0];
  endtask

  task automatic test_oneshot();
    logic [cnt_w-1:0] cnt;
    run_near_max(1'b1, cnt);
    check_count("one-shot saturation", cnt_max, cnt);
  endtask

  task automatic test_wrap();
    logic [cnt_w-1:0] cnt;
    run_near_max(1'b0, cnt);
    check_flag($sformatf("wrap count %0d below 10", cnt), 1'b1, cnt < cnt_w'(10));
  endtask

  // load a value and compare count, status bit and pin against exp
  task automatic watermark_step(input string name, input logic [cnt_w-1:0] val,
                                input logic exp);
    logic [data_w-1:0] d;
    write_csr(CSR_LOAD, data_w'(val));
    write_csr(CSR_CTRL, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0));
    read_csr(CSR_COUNT, d);                          // also gives the flag time to follow
    check_count({name, " count"}, val, d[cnt_w-1:0]);
    read_csr(CSR_STATUS, d);
    check_flag({name, " status"}, exp, d[status_wmark_bit]);
    check_flag({name, " pin"}, exp, at_watermark);
  endtask

  task automatic test_watermark();
    logic [cnt_w-1:0] wm;
    wm = cnt_w'($urandom) | cnt_w'(1);               // nonzero so wm-1 exists
    write_csr(CSR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0));
    write_csr(CSR_WMARK, data_w'(wm));
    watermark_step("watermark below", wm - cnt_w'(1), 1'b0);
    watermark_step("watermark equal", wm, 1'b1);
  endtask

  // ----------------------------
  // run
  // ----------------------------
  initial
  begin
    void'($urandom(19));                             // fixed seed
    clk_main_a0 = 1'b0;
    rst_main_n  = 1'b0;
    wr_en       = 1'b0;
    wr_addr     = CSR_ID;
    wr_data     = '0;
    rd_en       = 1'b0;
    rd_addr     = CSR_ID;
    repeat (4) @(posedge clk_main_a0);
    rst_main_n <= 1'b1;
    test_identity();
    test_load_clear();
    test_tick_rate();
    test_oneshot();
    test_wrap();
    test_watermark();
    $display("RESULT: PASS");
    $finish;
  end

  initial
  begin
    #(2 * test_cycles * 4);                          // twice the budget, in ns
    $display("watchdog expired, the tests did not finish in time");
    stop_on_error();
  end

endmodule

/* project.f */
src/dbg_cnt_pkg.sv
src/csr_block.sv
src/tick_prescaler.sv
src/event_counter.sv
src/dbg_cnt_top.sv
bench/dbg_cnt_asserts.sv
bench/tb_dbg_cnt.sv

/* src/csr_block.sv */
// ----------------------------
// host register file of the debug counter
// holds the control registers, turns load and clear
// writes into one cycle pulses, registered readback
// ----------------------------

`timescale 1ns/1ps

module csr_block
  import dbg_cnt_pkg::*;
#(
  parameter int cnt_w  = 16,                         // event counter width
  parameter int tick_w = 8                           // prescaler width
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n,              // sync, active low
  // host write port
  input  logic              wr_en,
  input  csr_addr_e         wr_addr,
  input  logic [data_w-1:0] wr_data,
  // host read port
  input  logic              rd_en,
  input  csr_addr_e         rd_addr,
  output logic [data_w-1:0] rd_data,                 // valid with rd_valid
  output logic              rd_valid,                // rd_en delayed one cycle
  // counter control
  output logic              cnt_enable,
  output logic              cnt_oneshot,
  output logic              cnt_load,                // one cycle pulse
  output logic              cnt_clear,               // one cycle pulse
  output logic [tick_w-1:0] tick_value,
  output logic [cnt_w-1:0]  load_value,
  output logic [cnt_w-1:0]  watermark,
  // counter state
  input  logic [cnt_w-1:0]  count,
  input  logic              at_watermark
);

  logic              ctrl_wr;                        // write hits CSR_CTRL
  logic [data_w-1:0] ctrl_rd;                        // ctrl as seen by a read
  logic [data_w-1:0] status_rd;                      // status as seen by a read

  assign ctrl_wr = wr_en && (wr_addr == CSR_CTRL);

  // ----------------------------
  // write side
  // ----------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      cnt_enable  <= 1'b0;
      cnt_oneshot <= 1'b0;
      cnt_load    <= 1'b0;
      cnt_clear   <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end
    else
    begin
      cnt_load  <= ctrl_wr && wr_data[CTRL_LOAD];     // high only the cycle after the write
      cnt_clear <= ctrl_wr && wr_data[CTRL_CLEAR];
      if (ctrl_wr)
      begin
        cnt_enable  <= wr_data[CTRL_ENABLE];
        cnt_oneshot <= wr_data[CTRL_ONESHOT];
      end
      if (wr_en && (wr_addr == CSR_TICK))
        tick_value <= wr_data[tick_w-1:0];
      if (wr_en && (wr_addr == CSR_LOAD))
        load_value <= wr_data[cnt_w-1:0];
      if (wr_en && (wr_addr == CSR_WMARK))
        watermark <= wr_data[cnt_w-1:0];              // ro addresses fall through, ignored
    end
  end

  // ----------------------------
  // read side
  // ----------------------------
  always_comb
  begin
    ctrl_rd                   = '0;
    ctrl_rd[CTRL_ENABLE]      = cnt_enable;
    ctrl_rd[CTRL_ONESHOT]     = cnt_oneshot;          // pulse bits always read back 0
    status_rd                 = '0;
    status_rd[status_wmark_bit] = at_watermark;
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      rd_valid <= 1'b0;
    else
      rd_valid <= rd_en;
  end

  // read data register qualified by rd_valid
  always_ff @(posedge clk_main_a0)
  begin
    if (rd_en)
    begin
      case (rd_addr)
        CSR_ID:      rd_data <= dbg_id_value;
        CSR_VERSION: rd_data <= dbg_version_value;
        CSR_CTRL:    rd_data <= ctrl_rd;
        CSR_TICK:    rd_data <= data_w'(tick_value);
        CSR_LOAD:    rd_data <= data_w'(load_value);
        CSR_WMARK:   rd_data <= data_w'(watermark);
        CSR_COUNT:   rd_data <= data_w'(count);   // live count
        CSR_STATUS:  rd_data <= status_rd;
        default:     rd_data <= '0;
      endcase
    end
  end

endmodule

/* src/dbg_cnt_pkg.sv */
// ----------------------------
// debug counter shared definitions
// register port widths, register map, control bits
// and the identity words returned to the host
// ----------------------------

package dbg_cnt_pkg;

  // ----------------------------
  // register port widths
  // ----------------------------
  localparam int data_w = 32;                        // host data bus
  localparam int addr_w = 3;                         // eight word registers

  // ----------------------------
  // register map
  // ----------------------------
  typedef enum logic [addr_w-1:0] {
    CSR_ID      = 3'd0,                              // ro, identity word
    CSR_VERSION = 3'd1,                              // ro, version word
    CSR_CTRL    = 3'd2,                              // enable, oneshot, load, clear
    CSR_TICK    = 3'd3,                              // prescaler divide value
    CSR_LOAD    = 3'd4,                              // count preload value
    CSR_WMARK   = 3'd5,                              // watermark threshold
    CSR_COUNT   = 3'd6,                              // ro, live count
    CSR_STATUS  = 3'd7                               // ro, status flags
  } csr_addr_e;

  // bit positions inside CSR_CTRL
  typedef enum logic [1:0] {
    CTRL_ENABLE  = 2'd0,                             // level, run prescaler and counter
    CTRL_ONESHOT = 2'd1,                             // level, saturate at max
    CTRL_LOAD    = 2'd2,                             // self clearing, preload count
    CTRL_CLEAR   = 2'd3                              // self clearing, zero count and ticks
  } ctrl_bit_e;

  // ----------------------------
  // identity and status
  // ----------------------------
  localparam logic [data_w-1:0] dbg_id_value      = 32'hdb6c_0001;   // block identity
  localparam logic [data_w-1:0] dbg_version_value = 32'h0001_0200;   // major.minor.patch

  // CSR_STATUS layout
  localparam int status_wmark_bit = 0;               // count >= watermark

endpackage

/* src/dbg_cnt_top.sv */
// ----------------------------
// debug tick and event counter, top level
// register file -> prescaler -> counter -> readback
// ----------------------------

`timescale 1ns/1ps

module dbg_cnt_top
  import dbg_cnt_pkg::*;
#(
  parameter int cnt_w  = 16,                         // event counter width
  parameter int tick_w = 8                           // prescaler width
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n,              // sync, active low
  // host write port
  input  logic              wr_en,
  input  csr_addr_e         wr_addr,
  input  logic [data_w-1:0] wr_data,
  // host read port
  input  logic              rd_en,
  input  csr_addr_e         rd_addr,
  output logic [data_w-1:0] rd_data,
  output logic              rd_valid,
  // observation
  output logic              tick,
  output logic              at_watermark
);

  // ----------------------------
  // internal wires
  // ----------------------------
  logic              cnt_enable;
  logic              cnt_oneshot;
  logic              cnt_load;
  logic              cnt_clear;
  logic [tick_w-1:0] tick_value;
  logic [cnt_w-1:0]  load_value;
  logic [cnt_w-1:0]  watermark;
  logic [cnt_w-1:0]  count;

  csr_block #(
    .cnt_w  (cnt_w),
    .tick_w (tick_w)
  ) u_csr (
    .clk_main_a0  (clk_main_a0),
    .rst_main_n   (rst_main_n),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .cnt_enable   (cnt_enable),
    .cnt_oneshot  (cnt_oneshot),
    .cnt_load     (cnt_load),
    .cnt_clear    (cnt_clear),
    .tick_value   (tick_value),
    .load_value   (load_value),
    .watermark    (watermark),
    .count        (count),                           // back from the counter
    .at_watermark (at_watermark)
  );

  tick_prescaler #(
    .tick_w (tick_w)
  ) u_presc (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .cnt_enable  (cnt_enable),
    .cnt_clear   (cnt_clear),
    .tick_value  (tick_value),
    .tick        (tick)
  );

  event_counter #(
    .cnt_w (cnt_w)
  ) u_cnt (
    .clk_main_a0  (clk_main_a0),
    .rst_main_n   (rst_main_n),
    .tick         (tick),
    .cnt_oneshot  (cnt_oneshot),
    .cnt_load     (cnt_load),
    .cnt_clear    (cnt_clear),
    .load_value   (load_value),
    .watermark    (watermark),
    .count        (count),
    .at_watermark (at_watermark)
  );

endmodule

/* src/event_counter.sv */
// ----------------------------
// event counter
// counts prescaler ticks with clear, load, one-shot
// saturation and a registered watermark compare
// ----------------------------

`timescale 1ns/1ps

module event_counter
  import dbg_cnt_pkg::*;
#(
  parameter int cnt_w = 16                           // counter width
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n,               // sync, active low
  input  logic             tick,                     // increment request
  input  logic             cnt_oneshot,              // stop at max instead of wrap
  input  logic             cnt_load,                 // preload pulse
  input  logic             cnt_clear,                // zero pulse
  input  logic [cnt_w-1:0] load_value,
  input  logic [cnt_w-1:0] watermark,
  output logic [cnt_w-1:0] count,
  output logic             at_watermark              // count >= watermark, one cycle late
);

  localparam logic [cnt_w-1:0] cnt_max = '1;         // all ones

  logic at_max;                                      // next increment would wrap
  logic hold_max;                                    // one-shot stop

  assign at_max   = (count == cnt_max);
  assign hold_max = cnt_oneshot && at_max;

  // ----------------------------
  // count update
  // ----------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      count <= '0;
    else if (cnt_clear)
      count <= '0;                                   // highest priority
    else if (cnt_load)
      count <= load_value;
    else if (tick && !hold_max)
      count <= count + 1'b1;                         // wraps to 0 when not one-shot
    // tick at max in one-shot mode, count stays put
  end

  // ----------------------------
  // watermark flag
  // ----------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      at_watermark <= 1'b0;
    else
      at_watermark <= (count >= watermark);          // tracks count a cycle behind
  end

endmodule

/* src/tick_prescaler.sv */
// ----------------------------
// tick prescaler
// one tick every tick_value+1 enabled cycles
// ----------------------------

`timescale 1ns/1ps

module tick_prescaler
  import dbg_cnt_pkg::*;
#(
  parameter int tick_w = 8                           // divider width
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n,              // sync, active low
  input  logic              cnt_enable,              // run / hold
  input  logic              cnt_clear,               // restart the divider
  input  logic [tick_w-1:0] tick_value,              // terminal count
  output logic              tick                     // one cycle per period
);

  logic [tick_w-1:0] tick_cnt;                       // divider state
  logic              at_end;                         // terminal count reached

  // >= so a smaller tick_value written mid period still wraps
  assign at_end = (tick_cnt >= tick_value);
  assign tick   = cnt_enable && at_end;              // never while disabled

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      tick_cnt <= '0;
    else if (cnt_clear)
      tick_cnt <= '0;                                // clear beats enable
    else if (cnt_enable)
    begin
      if (at_end)
        tick_cnt <= '0;                              // wrap with the tick
      else
        tick_cnt <= tick_cnt + 1'b1;
    end
    // disabled, hold
  end

endmodule
